// File: source/lockstep_pkg.sv
//////////////////////////////
// Offsets, bus constants and bus structs shared by the checker and its core
// Integrity uses an inverted 39/32 Hsiao code and check bit k uses mask k
//////////////////////////////
package lockstep_pkg;

  //////////////////////////////
  // Lockstep timing
  //////////////////////////////

  // Shadow core lag behind the main core
  localparam int LOCKSTEP_OFFSET = 2;
  // Main outputs wait one more cycle for the shadow output register
  localparam int OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  // Width of the shadow reset counter, never below one bit
  localparam int LOCKSTEP_CNT_W  = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  //////////////////////////////
  // Bus and integrity
  //////////////////////////////

  localparam int DATA_W = 32;
  localparam int INTG_W = 7;

  // Last entry is the mask for check bit 0
  localparam logic [INTG_W-1:0][DATA_W-1:0] INTG_MASKS = {
    32'h9850_5586,
    32'h2DCC_624C,
    32'hC2C1_323B,
    32'h3123_4ED1,
    32'h413D_89AA,
    32'hDEBA_8050,
    32'h2606_BD25
  };

  // Keeps an all-zero word from carrying all-zero check bits
  localparam logic [INTG_W-1:0] INTG_INV = 7'h2A;

  //////////////////////////////
  // Core program
  //////////////////////////////

  localparam logic [DATA_W-1:0] START_ADDR  = 32'h0000_1000;
  localparam logic [DATA_W-1:0] RESULT_ADDR = 32'h0000_0F00;
  localparam int                GROUP_LEN   = 4;
  localparam int                GROUP_CNT_W = $clog2(GROUP_LEN);

  // Inputs of one core copy, 35 bits
  typedef struct packed {
    logic              data_gnt;
    logic              data_rvalid;
    logic [DATA_W-1:0] data_rdata;
    logic              fetch_enable;
  } core_in_t;

  // Outputs of one core copy, 70 bits
  typedef struct packed {
    logic              data_req;
    logic              data_we;
    logic [3:0]        data_be;
    logic [DATA_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
  } core_out_t;

endpackage

// File: source/lockstep_rst_seq.sv
//////////////////////////////
// Shadow reset is released LOCKSTEP_OFFSET edges after rst_ni and
// comparison starts one edge later, both drop at once on rst_ni
//////////////////////////////
`timescale 1ns/10ps

module lockstep_rst_seq (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_en_o
);
  import lockstep_pkg::*;

  logic [LOCKSTEP_CNT_W-1:0] cnt_q;
  logic [LOCKSTEP_CNT_W-1:0] cnt_d;
  logic                      set_d;
  logic                      set_q;
  logic                      cmp_en_q;

  // Counter stops once the release point is reached
  assign set_d = (cnt_q == LOCKSTEP_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + LOCKSTEP_CNT_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      set_q    <= set_d;
      cmp_en_q <= set_q;
    end
  end

  // Flop output acts directly as the shadow core's async reset
  assign shadow_rst_no = set_q;
  assign cmp_en_o      = cmp_en_q;

endmodule

// File: source/lockstep_delay.sv
//////////////////////////////
// Output repeats the input from exactly DEPTH cycles earlier
// payload_t must be a packed type and DEPTH at least 1
//////////////////////////////
`timescale 1ns/10ps

module lockstep_delay #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t d_i,
  output payload_t q_o
);

  // Stage 0 takes the input, the last stage drives the output
  payload_t [DEPTH-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= d_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q_o = stage_q[DEPTH-1];

endmodule

// File: source/bus_intg_check.sv
//////////////////////////////
// Read side is checked one cycle after rvalid
// Write integrity is combinational from wdata_i
//////////////////////////////
`timescale 1ns/10ps

module bus_intg_check (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rvalid_i,
  input  logic [lockstep_pkg::DATA_W-1:0] rdata_i,
  input  logic [lockstep_pkg::INTG_W-1:0] rintg_i,
  input  logic [lockstep_pkg::DATA_W-1:0] wdata_i,
  output logic [lockstep_pkg::INTG_W-1:0] wintg_o,
  output logic                            intg_err_o
);
  import lockstep_pkg::*;

  // Check bits for one data word
  function automatic logic [INTG_W-1:0] intg_enc(logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] chk;
    for (int k = 0; k < INTG_W; k++) begin
      chk[k] = ^(data & INTG_MASKS[k]);
    end
    return chk ^ INTG_INV;
  endfunction

  //////////////////////////////
  // Read data check
  //////////////////////////////

  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [INTG_W-1:0] rintg_q;
  logic [INTG_W-1:0] rintg_calc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      rintg_q  <= '0;
    end else begin
      rvalid_q <= rvalid_i;
      rdata_q  <= rdata_i;
      rintg_q  <= rintg_i;
    end
  end

  assign rintg_calc = intg_enc(rdata_q);

  // Check bits outside a valid beat carry no meaning
  assign intg_err_o = rvalid_q & (rintg_calc != rintg_q);

  //////////////////////////////
  // Write data encoding
  //////////////////////////////

  assign wintg_o = intg_enc(wdata_i);

endmodule

// File: source/acc_core.sv
//////////////////////////////
// Reads consecutive words from START_ADDR and writes each sum of
// GROUP_LEN words to RESULT_ADDR, outputs come from flops only
//////////////////////////////
`timescale 1ns/10ps

module acc_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_i,
  output lockstep_pkg::core_out_t core_o
);
  import lockstep_pkg::*;

  typedef enum logic [1:0] {
    ST_READ_REQ,
    ST_READ_WAIT,
    ST_WRITE_REQ
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  logic [DATA_W-1:0]      addr_q;
  logic [DATA_W-1:0]      addr_d;
  logic [DATA_W-1:0]      sum_q;
  logic [DATA_W-1:0]      sum_d;
  logic [GROUP_CNT_W-1:0] cnt_q;
  logic [GROUP_CNT_W-1:0] cnt_d;
  logic                   fetch_en_q;
  logic                   req_accepted;

  assign req_accepted = core_o.data_req & core_i.data_gnt;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    sum_d   = sum_q;
    cnt_d   = cnt_q;

    case (state_q)
      ST_READ_REQ: begin
        if (req_accepted) begin
          state_d = ST_READ_WAIT;
        end
      end
      ST_READ_WAIT: begin
        if (core_i.data_rvalid) begin
          sum_d  = sum_q + core_i.data_rdata;
          addr_d = addr_q + DATA_W'(4);
          // Counter wraps to zero after the last read of a group
          cnt_d  = cnt_q + GROUP_CNT_W'(1);
          if (cnt_q == GROUP_CNT_W'(GROUP_LEN - 1)) begin
            state_d = ST_WRITE_REQ;
          end else begin
            state_d = ST_READ_REQ;
          end
        end
      end
      ST_WRITE_REQ: begin
        // Write completes on its grant, no rvalid follows
        if (req_accepted) begin
          sum_d   = '0;
          state_d = ST_READ_REQ;
        end
      end
      default: begin
        state_d = ST_READ_REQ;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_READ_REQ;
      addr_q     <= START_ADDR;
      sum_q      <= '0;
      cnt_q      <= '0;
      fetch_en_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      addr_q     <= addr_d;
      sum_q      <= sum_d;
      cnt_q      <= cnt_d;
      fetch_en_q <= core_i.fetch_enable;
    end
  end

  //////////////////////////////
  // Bus outputs
  //////////////////////////////

  // Reads wait for the registered fetch enable, a pending write does not
  assign core_o.data_req   = (state_q == ST_WRITE_REQ) |
                             ((state_q == ST_READ_REQ) & fetch_en_q);
  assign core_o.data_we    = (state_q == ST_WRITE_REQ);
  assign core_o.data_be    = 4'hF;
  assign core_o.data_addr  = (state_q == ST_WRITE_REQ) ? RESULT_ADDR : addr_q;
  assign core_o.data_wdata = sum_q;

endmodule

// File: source/lockstep_top.sv
//////////////////////////////
// Shadow core sees main inputs LOCKSTEP_OFFSET cycles late and its
// registered outputs meet main outputs delayed by OUTPUTS_OFFSET
//////////////////////////////
`timescale 1ns/10ps

module lockstep_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  lockstep_pkg::core_in_t          core_in_i,
  input  lockstep_pkg::core_out_t         core_out_i,
  input  logic [lockstep_pkg::INTG_W-1:0] data_rintg_i,
  output logic [lockstep_pkg::INTG_W-1:0] data_wintg_o,
  output logic                            alert_major_internal_o,
  output logic                            alert_major_bus_o
);
  import lockstep_pkg::*;

  logic      shadow_rst_n;
  logic      cmp_en;
  core_in_t  shadow_in;
  core_out_t main_out_dly;
  core_out_t shadow_out_d;
  core_out_t shadow_out_q;
  logic      bus_intg_err;

  //////////////////////////////
  // Shadow reset
  //////////////////////////////

  lockstep_rst_seq u_rst_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  //////////////////////////////
  // Delay lines
  //////////////////////////////

  lockstep_delay #(
    .payload_t (core_in_t),
    .DEPTH     (LOCKSTEP_OFFSET)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (core_in_i),
    .q_o    (shadow_in)
  );

  lockstep_delay #(
    .payload_t (core_out_t),
    .DEPTH     (OUTPUTS_OFFSET)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (core_out_i),
    .q_o    (main_out_dly)
  );

  //////////////////////////////
  // Shadow core
  //////////////////////////////

  acc_core u_shadow_core (
    .clk_i  (clk_i),
    .rst_ni (shadow_rst_n),
    .core_i (shadow_in),
    .core_o (shadow_out_d)
  );

  // One register stage, matched by the extra cycle on the main side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_out_q <= '0;
    end else begin
      shadow_out_q <= shadow_out_d;
    end
  end

  //////////////////////////////
  // Bus integrity
  //////////////////////////////

  // Read side uses the undelayed main-core bus
  bus_intg_check u_intg (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rvalid_i   (core_in_i.data_rvalid),
    .rdata_i    (core_in_i.data_rdata),
    .rintg_i    (data_rintg_i),
    .wdata_i    (core_out_i.data_wdata),
    .wintg_o    (data_wintg_o),
    .intg_err_o (bus_intg_err)
  );

  //////////////////////////////
  // Output comparison
  //////////////////////////////

  assign alert_major_internal_o = cmp_en & (shadow_out_q != main_out_dly);
  assign alert_major_bus_o      = bus_intg_err;

endmodule

// File: sim/tb_clkgen.sv
//////////////////////////////
// Reset is released DRIVE_DLY_NS after the last reset edge
//////////////////////////////
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RST_CYCLES   = 5,
  parameter int DRIVE_DLY_NS = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #(DRIVE_DLY_NS);
    rst_no = 1'b1;
  end

endmodule

// File: sim/tb_lockstep.sv
//////////////////////////////
// Main core is a rule-based model driven 2 ns after each edge
// Outputs are sampled on the falling edge
//////////////////////////////
`timescale 1ns/10ps

module tb_lockstep;
  import lockstep_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          DRIVE_DLY  = 2;
  localparam int          NUM_READS  = 400;
  localparam logic [31:0] SEED       = 32'h8894;
  // Roughly 4.5 cycles per read plus writes and the fault phases
  localparam int          WATCHDOG_CYCLES = NUM_READS * 7 + 200;

  typedef enum logic [1:0] {
    M_READ_REQ,
    M_READ_WAIT,
    M_WRITE_REQ
  } mstate_e;

  typedef struct packed {
    mstate_e                st;
    logic [DATA_W-1:0]      addr;
    logic [DATA_W-1:0]      sum;
    logic [GROUP_CNT_W-1:0] cnt;
    logic                   fetch_en;
  } model_t;

  logic              clk;
  logic              rst_n;
  logic              rst_seen;
  core_in_t          core_in;
  core_out_t         core_out;
  logic [INTG_W-1:0] data_rintg;
  logic [INTG_W-1:0] data_wintg;
  logic              alert_int;
  logic              alert_bus;

  model_t      model;
  logic [31:0] rng;
  logic        rd_pend;
  int          rd_dly;
  int          reads_done;
  int          writes_done;
  int          read_limit;
  int          cycle;
  // Fault in the current cycle sits at index 0
  logic [3:0]  out_hist;
  logic [1:0]  bus_hist;
  int          flip_req;
  int          flip_done;
  int          bad_valid_req;
  int          bad_valid_done;
  int          bad_idle_req;
  int          bad_idle_done;
  int          int_errs;
  int          bus_errs;
  int          wintg_errs;

  tb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RST_CYCLES   (5),
    .DRIVE_DLY_NS (DRIVE_DLY)
  ) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lockstep_top dut0 (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .core_in_i              (core_in),
    .core_out_i             (core_out),
    .data_rintg_i           (data_rintg),
    .data_wintg_o           (data_wintg),
    .alert_major_internal_o (alert_int),
    .alert_major_bus_o      (alert_bus)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Check bit k is the parity of the masked word, then inverted by INTG_INV
  function automatic logic [INTG_W-1:0] check_bits(input logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] bits;
    for (int k = 0; k < INTG_W; k++) begin
      bits[k] = ^(data & INTG_MASKS[k]);
    end
    return bits ^ INTG_INV;
  endfunction

  //////////////////////////////
  // Main-core reference model
  //////////////////////////////

  function automatic model_t model_reset();
    model_t m;
    m.st       = M_READ_REQ;
    m.addr     = START_ADDR;
    m.sum      = '0;
    m.cnt      = '0;
    m.fetch_en = 1'b0;
    return m;
  endfunction

  function automatic core_out_t model_out(input model_t m);
    core_out_t o;
    o.data_req   = (m.st == M_WRITE_REQ) || ((m.st == M_READ_REQ) && m.fetch_en);
    o.data_we    = (m.st == M_WRITE_REQ);
    o.data_be    = 4'hF;
    o.data_addr  = (m.st == M_WRITE_REQ) ? RESULT_ADDR : m.addr;
    o.data_wdata = m.sum;
    return o;
  endfunction

  function automatic model_t model_step(input model_t m, input core_in_t bus_in);
    model_t    n;
    core_out_t o;
    n = m;
    o = model_out(m);
    n.fetch_en = bus_in.fetch_enable;
    case (m.st)
      M_READ_REQ: begin
        if (o.data_req && bus_in.data_gnt) begin
          n.st = M_READ_WAIT;
        end
      end
      M_READ_WAIT: begin
        if (bus_in.data_rvalid) begin
          n.sum  = m.sum + bus_in.data_rdata;
          n.addr = m.addr + 32'd4;
          n.cnt  = m.cnt + GROUP_CNT_W'(1);
          n.st   = (m.cnt == GROUP_CNT_W'(GROUP_LEN - 1)) ? M_WRITE_REQ : M_READ_REQ;
        end
      end
      M_WRITE_REQ: begin
        if (bus_in.data_gnt) begin
          n.sum = '0;
          n.st  = M_READ_REQ;
        end
      end
      default: begin
        n.st = M_READ_REQ;
      end
    endcase
    return n;
  endfunction

  //////////////////////////////
  // Stimulus and memory model
  //////////////////////////////

  task automatic drive_cycle(input logic run);
    core_in_t          nxt;
    core_out_t         out;
    logic [INTG_W-1:0] rintg;
    logic              out_fault;
    logic              bus_fault;
    nxt       = '0;
    out_fault = 1'b0;
    bus_fault = 1'b0;
    if (!run) begin
      model   = model_reset();
      rd_pend = 1'b0;
      rd_dly  = 0;
    end else begin
      model = model_step(model, core_in);
    end
    out = model_out(model);
    if (run) begin
      rng = xorshift32(rng);
      nxt.data_rdata = rng;
      // Read data returns 1 to 3 cycles after its grant
      if (rd_pend) begin
        if (rd_dly <= 1) begin
          nxt.data_rvalid = 1'b1;
          rd_pend         = 1'b0;
          reads_done++;
        end else begin
          rd_dly = rd_dly - 1;
        end
      end
      if (out.data_req) begin
        rng = xorshift32(rng);
        nxt.data_gnt = rng[16];
      end
      if (nxt.data_gnt && !out.data_we) begin
        rng     = xorshift32(rng);
        rd_pend = 1'b1;
        rd_dly  = 1 + int'(rng % 32'd3);
      end
      if (nxt.data_gnt && out.data_we) begin
        writes_done++;
      end
      nxt.fetch_enable = (reads_done < read_limit);
    end
    rintg = check_bits(nxt.data_rdata);

    if (run && (flip_done != flip_req)) begin
      out.data_addr[5] = ~out.data_addr[5];
      out_fault        = 1'b1;
      flip_done++;
    end
    if (run && (bad_valid_done != bad_valid_req) && nxt.data_rvalid) begin
      rintg     = rintg ^ 7'h04;
      bus_fault = 1'b1;
      bad_valid_done++;
    end
    if (run && (bad_idle_done != bad_idle_req) && !nxt.data_rvalid) begin
      rintg = rintg ^ 7'h40;
      bad_idle_done++;
    end

    out_hist   = {out_hist[2:0], out_fault};
    bus_hist   = {bus_hist[0], bus_fault};
    core_in    = nxt;
    core_out   = out;
    data_rintg = rintg;
    cycle++;
  endtask

  initial begin
    core_in        = '0;
    core_out       = '0;
    data_rintg     = check_bits('0);
    model          = model_reset();
    rng            = SEED;
    rd_pend        = 1'b0;
    rd_dly         = 0;
    reads_done     = 0;
    writes_done    = 0;
    cycle          = 0;
    out_hist       = '0;
    bus_hist       = '0;
    flip_done      = 0;
    bad_valid_done = 0;
    bad_idle_done  = 0;
    forever begin
      @(posedge clk);
      rst_seen = rst_n;
      #(DRIVE_DLY);
      drive_cycle(rst_seen);
    end
  end

  //////////////////////////////
  // Output checks
  //////////////////////////////

  initial begin
    int_errs   = 0;
    bus_errs   = 0;
    wintg_errs = 0;
  end

  always @(negedge clk) begin : compare_outputs
    logic [INTG_W-1:0] exp_wintg;
    exp_wintg = check_bits(core_out.data_wdata);
    assert (data_wintg === exp_wintg) else begin
      $display("FAIL data_wintg_o expected %h got %h in cycle %0d",
               exp_wintg, data_wintg, cycle);
      wintg_errs++;
    end
    assert (alert_int === out_hist[3]) else begin
      $display("FAIL alert_major_internal_o expected %h got %h in cycle %0d",
               out_hist[3], alert_int, cycle);
      int_errs++;
    end
    assert (alert_bus === bus_hist[1]) else begin
      $display("FAIL alert_major_bus_o expected %h got %h in cycle %0d",
               bus_hist[1], alert_bus, cycle);
      bus_errs++;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    read_limit    = NUM_READS;
    flip_req      = 0;
    bad_valid_req = 0;
    bad_idle_req  = 0;

    // Clean run of 400 reads and 100 sum writes
    while (writes_done < NUM_READS / GROUP_LEN) @(posedge clk);
    repeat (8) @(posedge clk);

    // One flipped address bit on the main-core outputs
    flip_req = flip_req + 1;
    while (flip_done != flip_req) @(posedge clk);
    repeat (8) @(posedge clk);

    // Bad check bits on a valid read beat, one more group of reads
    read_limit    = NUM_READS + GROUP_LEN;
    bad_valid_req = bad_valid_req + 1;
    while (bad_valid_done != bad_valid_req) @(posedge clk);
    while (writes_done < NUM_READS / GROUP_LEN + 1) @(posedge clk);
    repeat (8) @(posedge clk);

    // Bad check bits without rvalid must be ignored
    bad_idle_req = bad_idle_req + 1;
    while (bad_idle_done != bad_idle_req) @(posedge clk);
    repeat (8) @(posedge clk);

    $display("Error counts: internal alert %0d, bus alert %0d, write integrity %0d",
             int_errs, bus_errs, wintg_errs);
    if (int_errs + bus_errs + wintg_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: project.f
source/lockstep_pkg.sv
source/lockstep_rst_seq.sv
source/lockstep_delay.sv
source/bus_intg_check.sv
source/acc_core.sv
source/lockstep_top.sv
sim/tb_clkgen.sv
sim/tb_lockstep.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_lockstep -f project.f -Mdir obj_dir

out=$(./obj_dir/Vtb_lockstep)
echo "$out"

if echo "$out" | grep -q "^Test OK$"; then
  exit 0
else
  exit 1
fi
